/* source/gf_settings.svh */
/*
  GF(2^8) accelerator settings
  Field width, reduction polynomial, command FIFO depth and
  the Wishbone register map
*/
`ifndef GF_SETTINGS_SVH
`define GF_SETTINGS_SVH

// Field width in bits, the polynomial below is tied to it
`define GF_M 8

// AES polynomial x^8 + x^4 + x^3 + x + 1, top bit implied
`define GF_POLY 8'h1B

// Command FIFO entries
`define CMD_FIFO_DEPTH 4

// Register word addresses
`define WB_ADR_CMD 4'd0
`define WB_ADR_STATUS 4'd1

`endif

/* source/gf_pkg.sv */
/*
  GF(2^8) accelerator types
  Opcode and MAC state enums, command and result structs shared
  by the Wishbone slave, the command FIFO and the MAC unit
*/
`include "gf_settings.svh"

package gf_pkg;

  // ----------------------------------------------------------
  // Enums
  // ----------------------------------------------------------

  // Opcode, as written in bits 17:16 of the command register
  typedef enum logic [1:0] {
    OP_MUL = 2'd0,
    OP_SQR = 2'd1,
    OP_MAC = 2'd2,
    OP_CLR = 2'd3
  } gf_op_e;

  // Output register holds an unsent result in MAC_HOLD
  typedef enum logic {
    MAC_IDLE = 1'b0,
    MAC_HOLD = 1'b1
  } mac_state_e;

  // ----------------------------------------------------------
  // Structs
  // ----------------------------------------------------------

  // Command, 18 bits
  typedef struct packed {
    gf_op_e            op;
    logic [`GF_M-1:0]  a;
    logic [`GF_M-1:0]  b;
  } gf_cmd_t;

  // Result word, 10 bits
  typedef struct packed {
    gf_op_e            op;
    logic [`GF_M-1:0]  value;
  } gf_result_t;

endpackage

/* source/gf_mul_classic.sv */
/*
  GF(2^8) classic multiplier
  Carry-less polynomial product from an AND plane and XOR trees,
  then reduction modulo the field polynomial through a constant
  matrix built at elaboration. Purely combinational
*/
`include "gf_settings.svh"

module gf_mul_classic (
  input  logic [`GF_M-1:0] x0,
  input  logic [`GF_M-1:0] x1,
  output logic [`GF_M-1:0] y
);

  localparam int M = `GF_M;
  localparam int P = 2 * M - 1;

  // ----------------------------------------------------------
  // Polynomial product
  // ----------------------------------------------------------

  // AND plane, row i holds x0[i] times every bit of x1
  logic [M-1:0][M-1:0] and_plane;
  // Unreduced product, degree up to 2M-2
  logic [P-1:0]        prod;

  always_comb begin
    for (int i = 0; i < M; i++) begin
      for (int j = 0; j < M; j++) begin
        and_plane[i][j] = x0[i] & x1[j];
      end
    end
  end

  // Product bit k is the XOR of all terms with i + j == k
  always_comb begin
    prod = '0;
    for (int i = 0; i < M; i++) begin
      for (int j = 0; j < M; j++) begin
        prod[i+j] = prod[i+j] ^ and_plane[i][j];
      end
    end
  end

  // ----------------------------------------------------------
  // Reduction matrix
  // ----------------------------------------------------------

  // Row j is x^(M+j) mod f as an M-bit vector
  typedef logic [M-2:0][M-1:0] red_mat_t;

  function automatic red_mat_t build_red_mat();
    red_mat_t mat;
    logic [M-1:0] poly;
    poly   = `GF_POLY;
    // x^M folds straight onto the polynomial tail
    mat[0] = poly;
    for (int j = 1; j < M - 1; j++) begin
      // Multiply previous row by x, fold back on overflow
      mat[j] = {mat[j-1][M-2:0], 1'b0} ^ (mat[j-1][M-1] ? poly : '0);
    end
    return mat;
  endfunction

  localparam red_mat_t RED_MAT = build_red_mat();

  // ----------------------------------------------------------
  // Reduction
  // ----------------------------------------------------------

  always_comb begin
    for (int i = 0; i < M; i++) begin
      y[i] = prod[i];
      // Fold every high product bit through its matrix row
      for (int j = 0; j < M - 1; j++) begin
        y[i] = y[i] ^ (prod[M+j] & RED_MAT[j][i]);
      end
    end
  end

endmodule

/* source/wb_cmd_slave.sv */
/*
  Wishbone classic command slave
  Decodes the CMD and STATUS registers, acknowledges each cycle
  after one clock and pushes written commands into the FIFO.
  A command write to a full FIFO is held off until space frees
*/
`include "gf_settings.svh"

module wb_cmd_slave import gf_pkg::*; (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [3:0]  wb_adr,
  input  logic [31:0] wb_dat_w,
  input  logic [3:0]  fifo_level,
  input  logic        full,
  input  logic        result_valid,
  output logic        wb_ack,
  output logic [31:0] wb_dat_r,
  output logic        push,
  output gf_cmd_t     push_cmd
);

  // ----------------------------------------------------------
  // Decode
  // ----------------------------------------------------------

  logic        req;
  logic        cmd_wr;
  logic        stall;
  logic [31:0] status_word;
  logic [31:0] rd_data;

  // Live cycle not yet acknowledged
  assign req    = wb_cyc & wb_stb & ~wb_ack;
  assign cmd_wr = wb_we & (wb_adr == `WB_ADR_CMD);
  // Back-pressure, ack waits for the FIFO to drain
  assign stall  = cmd_wr & full;

  // Level in 3:0, full in 8, result_valid in 9
  assign status_word = {22'd0, result_valid, full, 4'd0, fifo_level};

  // Only STATUS reads back, all else returns zero
  assign rd_data = (!wb_we && wb_adr == `WB_ADR_STATUS) ? status_word : 32'd0;

  // ----------------------------------------------------------
  // Ack and push
  // ----------------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_ack <= 1'b0;
      push   <= 1'b0;
    end else begin
      // One clock pulse, the host drops stb after it
      wb_ack <= req & ~stall;
      // Push rides along with the ack of a CMD write
      push   <= req & cmd_wr & ~full;
    end
  end

  // Payload, captured on the accepting edge
  always_ff @(posedge clk) begin
    if (req && !stall) begin
      push_cmd.op <= gf_op_e'(wb_dat_w[17:16]);
      push_cmd.a  <= wb_dat_w[15:8];
      push_cmd.b  <= wb_dat_w[7:0];
      wb_dat_r    <= rd_data;
    end
  end

endmodule

/* source/cmd_fifo.sv */
/*
  Command FIFO
  Circular buffer of gf_cmd_t entries with an occupancy count.
  Head entry is presented without a register
*/
module cmd_fifo import gf_pkg::*; #(
  parameter int DEPTH = 4
) (
  input  logic    clk,
  input  logic    arst_n,
  input  logic    push,
  input  logic    pop,
  input  gf_cmd_t push_cmd,
  output gf_cmd_t pop_cmd,
  output logic    empty,
  output logic    full,
  output logic [3:0] level
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // ----------------------------------------------------------
  // Storage and pointers
  // ----------------------------------------------------------

  gf_cmd_t       mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [3:0]    count;
  logic          do_push;
  logic          do_pop;

  // Pointer step with wrap, depth need not be a power of two
  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  assign empty   = (count == 4'd0);
  assign full    = (count == 4'(DEPTH));
  assign level   = count;
  assign pop_cmd = mem[rd_ptr];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= 4'd0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // Push and pop together leave the level alone
      if (do_push && !do_pop) begin
        count <= count + 4'd1;
      end else if (do_pop && !do_push) begin
        count <= count - 4'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_cmd;
    end
  end

endmodule

/* source/gf_mac_unit.sv */
/*
  GF(2^8) MAC unit
  Pops commands from the FIFO, runs them through the classic
  multiplier, keeps the accumulator and holds one result in a
  valid/ready output register
*/
`include "gf_settings.svh"

module gf_mac_unit import gf_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  gf_cmd_t    pop_cmd,
  input  logic       empty,
  input  logic       result_ready,
  output logic       pop,
  output gf_result_t result,
  output logic       result_valid
);

  mac_state_e       state;
  logic [`GF_M-1:0] acc;
  logic [`GF_M-1:0] mul_b;
  logic [`GF_M-1:0] product;
  logic [`GF_M-1:0] mac_sum;
  logic [`GF_M-1:0] next_value;
  logic             take;

  // ----------------------------------------------------------
  // Datapath
  // ----------------------------------------------------------

  // Square reuses operand a on both inputs
  assign mul_b = (pop_cmd.op == OP_SQR) ? pop_cmd.a : pop_cmd.b;

  gf_mul_classic mul0 (
    .x0 (pop_cmd.a),
    .x1 (mul_b),
    .y  (product)
  );

  assign mac_sum = acc ^ product;

  always_comb begin
    case (pop_cmd.op)
      OP_MUL:  next_value = product;
      OP_SQR:  next_value = product;
      OP_MAC:  next_value = mac_sum;
      OP_CLR:  next_value = '0;
      default: next_value = '0;
    endcase
  end

  // ----------------------------------------------------------
  // Handshake
  // ----------------------------------------------------------

  assign result_valid = (state == MAC_HOLD);
  assign take         = result_valid & result_ready;
  // Pop into an empty register, or one being drained this clock
  assign pop          = ~empty & ((state == MAC_IDLE) | take);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= MAC_IDLE;
      acc   <= '0;
    end else begin
      if (pop) begin
        state <= MAC_HOLD;
      end else if (take) begin
        state <= MAC_IDLE;
      end
      // Accumulator only moves on MAC and CLR
      if (pop && pop_cmd.op == OP_MAC) begin
        acc <= mac_sum;
      end else if (pop && pop_cmd.op == OP_CLR) begin
        acc <= '0;
      end
    end
  end

  // Output register, stable while held
  always_ff @(posedge clk) begin
    if (pop) begin
      result.op    <= pop_cmd.op;
      result.value <= next_value;
    end
  end

endmodule

/* source/gf_accel_top.sv */
/*
  GF(2^8) accelerator top level
  Wishbone command slave feeding the command FIFO, drained by the
  MAC unit onto a valid/ready result stream
*/
`include "gf_settings.svh"

module gf_accel_top import gf_pkg::*; (
  input  logic        clk,
  input  logic        arst_n,
  // Wishbone classic slave
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [3:0]  wb_adr,
  input  logic [31:0] wb_dat_w,
  output logic        wb_ack,
  output logic [31:0] wb_dat_r,
  // Result stream
  output gf_result_t  result,
  output logic        result_valid,
  input  logic        result_ready
);

  // Slave to FIFO
  logic       push;
  gf_cmd_t    push_cmd;
  logic       full;
  logic [3:0] fifo_level;
  // FIFO to MAC unit
  gf_cmd_t    pop_cmd;
  logic       empty;
  logic       pop;

  wb_cmd_slave slave0 (
    .clk          (clk),
    .arst_n       (arst_n),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .fifo_level   (fifo_level),
    .full         (full),
    .result_valid (result_valid),
    .wb_ack       (wb_ack),
    .wb_dat_r     (wb_dat_r),
    .push         (push),
    .push_cmd     (push_cmd)
  );

  cmd_fifo #(
    .DEPTH (`CMD_FIFO_DEPTH)
  ) fifo0 (
    .clk      (clk),
    .arst_n   (arst_n),
    .push     (push),
    .pop      (pop),
    .push_cmd (push_cmd),
    .pop_cmd  (pop_cmd),
    .empty    (empty),
    .full     (full),
    .level    (fifo_level)
  );

  gf_mac_unit mac0 (
    .clk          (clk),
    .arst_n       (arst_n),
    .pop_cmd      (pop_cmd),
    .empty        (empty),
    .result_ready (result_ready),
    .pop          (pop),
    .result       (result),
    .result_valid (result_valid)
  );

endmodule

/* bench/tb_clock_gen.sv */
/*
  Testbench clock and reset
  Clock of period 40, reset held low for the first 2 cycles
*/
module tb_clock_gen (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (2) @(posedge clk);
    #5 arst_n = 1'b1;
  end

endmodule

/* bench/gf_accel_asserts.sv */
/*
  Accelerator protocol assertions
  Wishbone ack rules, FIFO push rule and result stream stability
*/
module gf_accel_asserts import gf_pkg::*; (
  input logic       clk,
  input logic       arst_n,
  input logic       wb_cyc,
  input logic       wb_stb,
  input logic       wb_ack,
  input logic       push,
  input logic       full,
  input gf_result_t result,
  input logic       result_valid,
  input logic       result_ready
);

  // Ack only answers a live cycle
  ack_needs_cycle: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(wb_ack) |-> $past(wb_cyc & wb_stb))
    else $error("wb_ack rose without cyc and stb");

  // Single clock ack pulse
  ack_one_clock: assert property (@(posedge clk) disable iff (!arst_n)
    wb_ack |=> !wb_ack)
    else $error("wb_ack held longer than one clock");

  no_push_when_full: assert property (@(posedge clk) disable iff (!arst_n)
    push |-> !full)
    else $error("push while FIFO full");

  // Held result must not move
  result_stable: assert property (@(posedge clk) disable iff (!arst_n)
    (result_valid && !result_ready) |=> (result_valid && $stable(result)))
    else $error("result changed while stalled");

endmodule

bind gf_accel_top gf_accel_asserts asrt0 (
  .clk          (clk),
  .arst_n       (arst_n),
  .wb_cyc       (wb_cyc),
  .wb_stb       (wb_stb),
  .wb_ack       (wb_ack),
  .push         (push),
  .full         (full),
  .result       (result),
  .result_valid (result_valid),
  .result_ready (result_ready)
);

/* bench/gf_result_checker.sv */
/*
  Result stream checker
  Loads expected results from the stimulus file, compares every
  accepted result in order and keeps the pass and fail counts
*/
module gf_result_checker import gf_pkg::*; (
  input logic       clk,
  input logic       arst_n,
  input gf_result_t result,
  input logic       result_valid,
  input logic       result_ready
);

  int         pass_count = 0;
  int         fail_count = 0;
  int         result_count = 0;
  logic [1:0] exp_op [$];
  logic [7:0] exp_value [$];

  // Expected column of every command line, in file order
  initial begin
    int          fd;
    int          n;
    logic [31:0] op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp;
    logic [31:0] stall;
    string       line;
    fd = $fopen("bench/gf_stimulus.txt", "r");
    if (fd == 0) begin
      report_error("cannot open stimulus file");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        n = $sscanf(line, "%h %h %h %h %h", op, a, b, exp, stall);
        // Opcodes above 3 are register tests with no result
        if (n == 5 && op < 4) begin
          exp_op.push_back(op[1:0]);
          exp_value.push_back(exp[7:0]);
        end
      end
      $fclose(fd);
    end
  end

  task automatic report_error(input string msg);
    fail_count++;
    $display("Error: %s", msg);
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      fail_count++;
      $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
    end else begin
      pass_count++;
      $display("[PASS] %s = 0x%08h", name, got);
    end
  endtask

  // Transfer happens on an edge with valid and ready both high
  always @(posedge clk) begin
    if (arst_n && result_valid && result_ready) begin
      if (result_count >= exp_op.size()) begin
        report_error("result arrived with no command left to match");
      end else if (result.op !== exp_op[result_count]) begin
        fail_count++;
        $display("[FAIL] result.op #%0d got 0x%0h expected 0x%0h",
                 result_count, result.op, exp_op[result_count]);
      end else if (result.value !== exp_value[result_count]) begin
        fail_count++;
        $display("[FAIL] result.value #%0d got 0x%02h expected 0x%02h",
                 result_count, result.value, exp_value[result_count]);
      end else begin
        pass_count++;
        $display("[PASS] result #%0d op %0d value 0x%02h",
                 result_count, result.op, result.value);
      end
      result_count++;
    end
  end

endmodule

/* bench/gf_accel_tb.sv */
/*
  GF(2^8) accelerator testbench
  Runs the stimulus file through Wishbone writes, stalls the
  result stream, checks back-pressure and the unused address
*/
`include "gf_settings.svh"

module gf_accel_tb import gf_pkg::*;;

  localparam int DRIVE_DELAY = 5;
  localparam int CYCLES_PER_LINE = 20;
  localparam int TIMEOUT_MARGIN = 200;

  logic        clk;
  logic        arst_n;
  logic        wb_cyc = 1'b0;
  logic        wb_stb = 1'b0;
  logic        wb_we = 1'b0;
  logic [3:0]  wb_adr = 4'd0;
  logic [31:0] wb_dat_w = 32'd0;
  logic        wb_ack;
  logic [31:0] wb_dat_r;
  gf_result_t  result;
  logic        result_valid;
  logic        result_ready = 1'b1;

  integer      seed = 32'h8ad8_7e96;
  logic [31:0] rand_word;
  int          ready_mode = 0;
  int          cycle_count = 0;
  int          timeout_limit = 32'h7fff_ffff;
  logic [31:0] line_op [$];
  logic [31:0] line_a [$];
  logic [31:0] line_b [$];
  logic [31:0] line_stall [$];

  tb_clock_gen clkgen0 (.clk(clk), .arst_n(arst_n));

  gf_accel_top dut0 (
    .clk (clk), .arst_n (arst_n),
    .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we),
    .wb_adr (wb_adr), .wb_dat_w (wb_dat_w),
    .wb_ack (wb_ack), .wb_dat_r (wb_dat_r),
    .result (result), .result_valid (result_valid),
    .result_ready (result_ready)
  );

  gf_result_checker chk0 (
    .clk (clk), .arst_n (arst_n), .result (result),
    .result_valid (result_valid), .result_ready (result_ready)
  );

  // ------------------------------------------------------------
  // Ready pattern and timeout
  // ------------------------------------------------------------

  // Mode 0 ready high, mode 1 random stalls, mode 2 held by the test
  always @(posedge clk) begin
    #DRIVE_DELAY;
    if (ready_mode == 1) begin
      rand_word = $random(seed);
      result_ready = rand_word[0];
    end else if (ready_mode == 0) begin
      result_ready = 1'b1;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_limit) begin
      $display("Timeout: run exceeded %0d cycles without finishing", timeout_limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Wishbone host
  // ------------------------------------------------------------

  task automatic wb_start(input logic we, input logic [3:0] adr, input logic [31:0] dat);
    @(posedge clk);
    #DRIVE_DELAY;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
  endtask

  // Waits for ack and then ends the cycle
  task automatic wb_finish(output logic [31:0] rdata);
    do @(negedge clk); while (!wb_ack);
    rdata = wb_dat_r;
    @(posedge clk);
    #DRIVE_DELAY;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] dat,
                           output logic [31:0] rdata);
    wb_start(we, adr, dat);
    wb_finish(rdata);
  endtask

  task automatic wait_results(input int n);
    while (chk0.result_count < n) @(posedge clk);
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------

  initial begin
    int          fd;
    int          n;
    int          issued;
    int          held;
    logic [31:0] op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp;
    logic [31:0] stall;
    logic [31:0] rdata;
    logic [31:0] cmd_word;
    string       line;
    issued = 0;
    held   = 0;
    fd = $fopen("bench/gf_stimulus.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        n = $sscanf(line, "%h %h %h %h %h", op, a, b, exp, stall);
        if (n == 5) begin
          line_op.push_back(op);
          line_a.push_back(a);
          line_b.push_back(b);
          line_stall.push_back(stall);
        end
      end
      $fclose(fd);
    end
    timeout_limit = line_op.size() * CYCLES_PER_LINE + TIMEOUT_MARGIN;
    @(posedge arst_n);
    for (int i = 0; i < line_op.size(); i++) begin
      cmd_word = {14'd0, line_op[i][1:0], line_a[i][7:0], line_b[i][7:0]};
      if (line_op[i] > 3) begin
        // Unused address reads zero and a write to it yields nothing
        wb_access(1'b0, 4'd2, 32'd0, rdata);
        chk0.check_word("wb_dat_r unused address", rdata, 32'd0);
        wb_access(1'b1, 4'd2, cmd_word, rdata);
      end else if (line_stall[i] == 2 && held == `CMD_FIFO_DEPTH + 1) begin
        // Output register and FIFO both full so this write must stall
        wb_start(1'b1, `WB_ADR_CMD, cmd_word);
        repeat (4) begin
          @(negedge clk);
          if (wb_ack) begin
            chk0.report_error("CMD write acknowledged while the FIFO was full");
          end
        end
        ready_mode = 0;
        wb_finish(rdata);
        held = 0;
        issued++;
      end else if (line_stall[i] == 2) begin
        if (held == 0) begin
          // Drain first so the fill starts from an empty path
          ready_mode = 0;
          wait_results(issued);
          @(posedge clk);
          #DRIVE_DELAY;
          ready_mode = 2;
          result_ready = 1'b0;
        end
        wb_access(1'b1, `WB_ADR_CMD, cmd_word, rdata);
        held++;
        issued++;
        if (held == `CMD_FIFO_DEPTH + 1) begin
          wb_access(1'b0, `WB_ADR_STATUS, 32'd0, rdata);
          chk0.check_word("wb_dat_r status", rdata,
                          (32'd1 << 9) | (32'd1 << 8) | 32'(`CMD_FIFO_DEPTH));
        end
      end else begin
        ready_mode = (line_stall[i] == 1) ? 1 : 0;
        wb_access(1'b1, `WB_ADR_CMD, cmd_word, rdata);
        issued++;
      end
    end
    ready_mode = 0;
    wait_results(issued);
    // Window for any extra result to show up
    repeat (10) @(posedge clk);
    if (chk0.result_count != issued) begin
      chk0.report_error("number of results differs from number of commands");
    end
    $display("Tests: %0d passed, %0d failed", chk0.pass_count, chk0.fail_count);
    if (chk0.fail_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+source
source/gf_pkg.sv
source/gf_mul_classic.sv
source/wb_cmd_slave.sv
source/cmd_fifo.sv
source/gf_mac_unit.sv
source/gf_accel_top.sv
bench/tb_clock_gen.sv
bench/gf_accel_asserts.sv
bench/gf_result_checker.sv
bench/gf_accel_tb.sv

/* Makefile */
# Verilator build and run of the GF(2^8) accelerator testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= gf_accel_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the simulation"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* bench/gf_stimulus.txt */
# op a b expected stall, all hex; op 0 MUL 1 SQR 2 MAC 3 CLR 4 unused address
# stall 0 ready high, 1 random ready, 2 ready held low for the back-pressure test
0 57 83 c1 0
0 57 00 00 0
0 01 a7 a7 0
0 57 57 a5 0
1 57 00 a5 0
1 80 00 9a 0
1 03 00 05 1
3 00 00 00 0
2 57 83 c1 0
2 57 13 3f 1
2 02 03 39 1
3 00 00 00 1
2 01 80 80 0
0 57 08 8e 1
0 57 10 07 1
0 02 80 1b 1
0 ff 01 ff 1
4 00 00 00 0
0 57 02 ae 2
0 57 04 47 2
0 57 20 0e 2
0 57 40 1c 2
0 57 01 57 2
0 00 57 00 2
